//--- all.f
+incdir+hw
hw/pixPkg.sv
hw/msbOneHot.sv
hw/quickLog2.sv
hw/proc2memArb.sv
hw/pixelEngine.sv
hw/frameBuffer.sv
hw/pixelSystem.sv
tests/pixelSystem_tb.sv

//--- hw/frameBuffer.sv
// Pixel memory with one write port and a registered read port.
// rdData follows rdAddr by one cycle; contents come up undefined.
`timescale 1ns/1ps
`include "pixArb_cfg.svh"

module frameBuffer import pixPkg::*; #(
  parameter int DEPTH = `FB_DEPTH
) (
  input  logic                clk,
  input  logic                wrEn,
  input  pixWrite_t           wr,
  input  logic [`ADDR_W-1:0]  rdAddr,
  output logic [`COLOR_W-1:0] rdData
);

  localparam int AW = $clog2(DEPTH);

  logic [`COLOR_W-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (wrEn) begin
      mem[wr.addr[AW-1:0]] <= wr.color;
    end
  end

  // read-before-write on a same-address collision
  always_ff @(posedge clk) begin
    rdData <= mem[rdAddr[AW-1:0]];
  end

  // full-width address must land inside the stored region
  assert property (@(posedge clk) wrEn |-> (32'(wr.addr) < DEPTH))
    else $error("write address beyond frame buffer depth");

endmodule

//--- hw/msbOneHot.sv
// Keeps only the highest set bit of a request vector.
`timescale 1ns/1ps

module msbOneHot #(
  parameter int WIDTH = 32
) (
  input  logic [WIDTH-1:0] in,
  output logic [WIDTH-1:0] out
);

  logic found;

  // scan down from the msb, first hit wins
  always_comb begin
    out   = '0;
    found = 1'b0;
    for (int i = WIDTH - 1; i >= 0; i--) begin
      if (in[i] && !found) begin
        out[i] = 1'b1;
        found  = 1'b1;
      end
    end
  end

  // at most one bit out, and only one that was requested
  always_comb begin
    assert ($onehot0(out) && ((out & ~in) == '0))
      else $error("msbOneHot output not a single requested bit");
  end

endmodule

//--- hw/pixArb_cfg.svh
// Sizing for the pixel-write subsystem.
// Include wherever engine count, address or color width is needed.
`ifndef PIXARB_CFG_SVH
`define PIXARB_CFG_SVH

// fill engines sharing the frame buffer, at most 32
`define NUM_PROCS 16

// full pixel address as carried on the write path
`define ADDR_W 19

// bits per pixel
`define COLOR_W 8

// words actually stored, kept small for simulation
`define FB_DEPTH 4096

`endif

//--- hw/pixPkg.sv
// Shared types for the pixel-write subsystem.
// Engines, arbiter and frame buffer import this package.
`include "pixArb_cfg.svh"

package pixPkg;

  // one pixel write as it travels to memory
  typedef struct packed {
    logic [`ADDR_W-1:0]  addr;
    logic [`COLOR_W-1:0] color;
  } pixWrite_t;

  // horizontal fill command for one engine
  typedef struct packed {
    logic [`ADDR_W-1:0]  base;   // first pixel
    logic [15:0]         count;  // zero draws nothing
    logic [`COLOR_W-1:0] color;
  } fillCmd_t;

  // binary engine index out of the log2 stage
  typedef logic [4:0] procIdx_t;

endpackage

//--- hw/pixelEngine.sv
// Horizontal fill engine: walks a run of addresses, one arbitrated write each.
// Start it with a one-cycle cmdValid while busy is low.
`timescale 1ns/1ps
`include "pixArb_cfg.svh"

module pixelEngine import pixPkg::*; (
  input  logic      clk,
  input  logic      arstN,
  input  logic      cmdValid,
  input  fillCmd_t  cmd,
  input  logic      grant,
  output logic      req,
  output pixWrite_t pix,
  output logic      busy
);

  logic [`ADDR_W-1:0]  curAddr;
  logic [15:0]         remain;    // pixels left including current
  logic [`COLOR_W-1:0] curColor;
  logic                lastPix;

  assign lastPix = (remain == 16'd1);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      busy <= 1'b0;
    end else if (cmdValid) begin
      busy <= (cmd.count != 16'd0);  // zero-length run stays idle
    end else if (grant && lastPix) begin
      busy <= 1'b0;
    end
  end

  // run state, only meaningful while busy
  always_ff @(posedge clk) begin
    if (cmdValid) begin
      curAddr  <= cmd.base;
      remain   <= cmd.count;
      curColor <= cmd.color;
    end else if (grant) begin
      curAddr <= curAddr + 1'b1;
      remain  <= remain - 16'd1;
    end
  end

  // request stays up for the whole run
  assign req       = busy;
  assign pix.addr  = curAddr;
  assign pix.color = curColor;

  assert property (@(posedge clk) disable iff (!arstN) !(cmdValid && busy))
    else $error("fill command while engine busy");

  assert property (@(posedge clk) disable iff (!arstN) grant |-> req)
    else $error("grant without request");

endmodule

//--- hw/pixelSystem.sv
// Top level: fill engines sharing one frame buffer through the arbiter.
// wr/wrEn are also brought out as a write tap.
`timescale 1ns/1ps
`include "pixArb_cfg.svh"

module pixelSystem import pixPkg::*; (
  input  logic                  clk,
  input  logic                  arstN,
  input  logic [`NUM_PROCS-1:0] cmdValid,
  input  fillCmd_t              cmd [`NUM_PROCS],
  output logic [`NUM_PROCS-1:0] busy,
  input  logic [`ADDR_W-1:0]    rdAddr,
  output logic [`COLOR_W-1:0]   rdData,
  output pixWrite_t             wr,
  output logic                  wrEn
);

  logic [`NUM_PROCS-1:0] req;
  logic [`NUM_PROCS-1:0] grant;
  pixWrite_t             pix [`NUM_PROCS];

  for (genvar i = 0; i < `NUM_PROCS; i++) begin : gEngine
    pixelEngine uEngine (
      .clk      (clk),
      .arstN    (arstN),
      .cmdValid (cmdValid[i]),
      .cmd      (cmd[i]),
      .grant    (grant[i]),
      .req      (req[i]),
      .pix      (pix[i]),
      .busy     (busy[i])
    );
  end

  proc2memArb #(
    .payload_t (pixWrite_t),
    .NUM       (`NUM_PROCS)
  ) uArb (
    .clk   (clk),
    .arstN (arstN),
    .req   (req),
    .pix   (pix),
    .grant (grant),
    .wr    (wr),
    .wrEn  (wrEn)
  );

  frameBuffer #(.DEPTH(`FB_DEPTH)) uFb (
    .clk    (clk),
    .wrEn   (wrEn),
    .wr     (wr),
    .rdAddr (rdAddr),
    .rdData (rdData)
  );

endmodule

//--- hw/proc2memArb.sv
// Fixed-priority arbiter from engine requests to one memory write per cycle.
// Highest-numbered requester wins; last cycle's winner sits out one round.
`timescale 1ns/1ps
`include "pixArb_cfg.svh"

module proc2memArb import pixPkg::*; #(
  parameter type payload_t = pixWrite_t,
  parameter int  NUM       = `NUM_PROCS
) (
  input  logic           clk,
  input  logic           arstN,
  input  logic [NUM-1:0] req,
  input  payload_t       pix [NUM],
  output logic [NUM-1:0] grant,
  output payload_t       wr,
  output logic           wrEn
);

  logic [NUM-1:0] masked;
  logic [31:0]    reqWide;
  logic [31:0]    oneHot;
  procIdx_t       winIdx;
  payload_t       selPix;

  // granted engine still holds req this cycle, keep it out
  assign masked  = req & ~grant;
  assign reqWide = 32'(masked);

  msbOneHot #(.WIDTH(32)) uMsb (
    .in  (reqWide),
    .out (oneHot)
  );

  quickLog2 #(.WIDTH(32)) uLog2 (
    .in  (oneHot),
    .idx (winIdx)
  );

  // payload mux driven by the encoded index
  always_comb begin
    selPix = pix[0];
    for (int i = 0; i < NUM; i++) begin
      if (int'(winIdx) == i) begin
        selPix = pix[i];
      end
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      grant <= '0;
      wrEn  <= 1'b0;
    end else begin
      grant <= oneHot[NUM-1:0];
      wrEn  <= |masked;
    end
  end

  always_ff @(posedge clk) begin
    if (|masked) begin
      wr <= selPix;  // held when idle
    end
  end

  assert property (@(posedge clk) disable iff (!arstN) $onehot0(grant))
    else $error("more than one engine granted");

  assert property (@(posedge clk) disable iff (!arstN) wrEn == (|grant))
    else $error("write strobe out of step with grant");

endmodule

//--- hw/quickLog2.sv
// One-hot to binary index encoder without a priority chain.
// Input must already be one-hot or zero.
`timescale 1ns/1ps

module quickLog2 import pixPkg::*; #(
  parameter int WIDTH = 32
) (
  input  logic [WIDTH-1:0] in,
  output procIdx_t         idx
);

  // each index bit is the OR of all inputs whose position has that bit set
  always_comb begin
    idx = '0;
    for (int i = 0; i < WIDTH; i++) begin
      for (int b = 0; b < $bits(procIdx_t); b++) begin
        if (i[b]) begin
          idx[b] = idx[b] | in[i];
        end
      end
    end
  end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Builds the pixel-write testbench with Verilator and runs it from the project root.
# Exit status is zero only when the simulation finishes without a fatal error.
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --timescale 1ns/1ps -f all.f \
    --top-module pixelSystem_tb -o pixelSim &&
  ./obj_dir/pixelSim ||
  { echo "simulation build or run failed"; exit 1; }

//--- tests/pixelSystem_tb.sv
// Vector-driven testbench for the pixel-write subsystem.
// Replays tests/pixelSystem_vectors.txt, run from the project root.
`timescale 1ns/1ps
`include "pixArb_cfg.svh"

module pixelSystem_tb import pixPkg::*; ();

  localparam int NP         = `NUM_PROCS;
  localparam int IDLE_LIMIT = 2000;  // cycles allowed for any run to drain

  logic                  clk;
  logic                  arstN;
  logic [NP-1:0]         cmdValid;
  fillCmd_t              cmd [NP];
  logic [NP-1:0]         busy;
  logic [`ADDR_W-1:0]    rdAddr;
  logic [`COLOR_W-1:0]   rdData;
  pixWrite_t             wr;
  logic                  wrEn;

  pixWrite_t tapLog [$];      // tap writes, oldest first
  fillCmd_t  staged [NP];     // commands waiting for the next strobe
  logic [NP-1:0] stagedMask;
  fillCmd_t  active [NP];     // runs started since the last tap audit
  logic [NP-1:0] activeMask;

  pixelSystem dut (
    .clk      (clk),
    .arstN    (arstN),
    .cmdValid (cmdValid),
    .cmd      (cmd),
    .busy     (busy),
    .rdAddr   (rdAddr),
    .rdData   (rdData),
    .wr       (wr),
    .wrEn     (wrEn)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // tap monitor, sampled mid-cycle
  always @(negedge clk) begin
    if (arstN && wrEn) begin
      tapLog.push_back(wr);
    end
  end

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic compareVal(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) begin
      abortRun($sformatf("mismatch %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // one-cycle strobe for every staged engine at once
  task automatic strobeStaged();
    @(posedge clk);
    for (int i = 0; i < NP; i++) begin
      if (stagedMask[i]) begin
        cmd[i] <= staged[i];
        active[i] = staged[i];
      end
    end
    cmdValid <= stagedMask;
    activeMask = activeMask | stagedMask;
    @(posedge clk);
    cmdValid <= '0;
    stagedMask = '0;
  endtask

  task automatic waitIdle();
    int n;
    n = 0;
    @(negedge clk);
    while (busy != '0) begin
      if (n == IDLE_LIMIT) begin
        abortRun("timeout: engines still busy after the idle limit");
      end
      n++;
      @(negedge clk);
    end
    @(posedge clk);  // step out of the monitor's sampling point
  endtask

  // nothing may move on the tap or busy lines
  task automatic holdQuiet(input int cycles);
    for (int k = 0; k < cycles; k++) begin
      @(negedge clk);
      compareVal("wrEn", 32'(wrEn), 32'd0);
      compareVal("busy", 32'(busy), 32'd0);
    end
  endtask

  task automatic popExpected(input int addr, input int color);
    pixWrite_t got;
    if (tapLog.size() == 0) begin
      abortRun("expected a write on the tap but none was seen");
    end
    got = tapLog.pop_front();
    compareVal("wr.addr", 32'(got.addr), 32'(addr));
    compareVal("wr.color", 32'(got.color), 32'(color));
  endtask

  // remaining writes must follow each active run in address order
  task automatic auditTap(input int expCount);
    logic [`ADDR_W-1:0] nextAddr [NP];
    logic [15:0]        left [NP];
    pixWrite_t          w;
    int                 owner;
    compareVal("write count", 32'(tapLog.size()), 32'(expCount));
    for (int i = 0; i < NP; i++) begin
      nextAddr[i] = active[i].base;
      left[i]     = active[i].count;
    end
    while (tapLog.size() > 0) begin
      w = tapLog.pop_front();
      owner = -1;
      for (int i = 0; i < NP; i++) begin
        if (activeMask[i] && left[i] != 16'd0 && w.addr == nextAddr[i]) begin
          owner = i;
        end
      end
      if (owner < 0) begin
        abortRun($sformatf("write to 0x%0h is repeated, out of order or unexpected",
                           w.addr));
      end
      compareVal("wr.color", 32'(w.color), 32'(active[owner].color));
      nextAddr[owner] = nextAddr[owner] + `ADDR_W'(1);
      left[owner]     = left[owner] - 16'd1;
    end
    activeMask = '0;
  endtask

  task automatic readRange(input int base, input int count, input int color);
    logic [`ADDR_W-1:0] a;
    a = `ADDR_W'(base);
    for (int k = 0; k < count; k++) begin
      @(posedge clk);
      rdAddr <= a;
      @(posedge clk);  // ram samples the address here
      @(negedge clk);
      compareVal($sformatf("rdData[0x%0h]", a), 32'(rdData), 32'(color));
      a = a + `ADDR_W'(1);
    end
  endtask

  initial begin
    int          fd;
    int          code;
    int          f1;
    int          f2;
    int          f3;
    int          f4;
    logic [7:0]  tok;
    logic [8*160-1:0] rest;
    cmdValid   = '0;
    rdAddr     = '0;
    arstN      = 1'b0;
    stagedMask = '0;
    activeMask = '0;
    for (int i = 0; i < NP; i++) begin
      cmd[i]    = '0;
      staged[i] = '0;
      active[i] = '0;
    end
    repeat (5) @(posedge clk);
    arstN <= 1'b1;

    fd = $fopen("tests/pixelSystem_vectors.txt", "r");
    if (fd == 0) begin
      abortRun("could not open the vector file tests/pixelSystem_vectors.txt");
    end
    while (1) begin
      code = $fscanf(fd, "%s", tok);
      if (code != 1) break;
      case (tok)
        "#": code = $fgets(rest, fd);  // comment line
        "c": begin
          if ($fscanf(fd, "%d %h %d %h", f1, f2, f3, f4) != 4 || f1 < 0 || f1 >= NP) begin
            abortRun("malformed command record in the vector file");
          end
          staged[f1].base  = `ADDR_W'(f2);
          staged[f1].count = 16'(f3);
          staged[f1].color = `COLOR_W'(f4);
          stagedMask[f1]   = 1'b1;
        end
        "s": strobeStaged();
        "i": waitIdle();
        "q": begin
          if ($fscanf(fd, "%d", f1) != 1) abortRun("malformed quiet record");
          holdQuiet(f1);
        end
        "e": begin
          if ($fscanf(fd, "%h %h", f1, f2) != 2) abortRun("malformed write record");
          popExpected(f1, f2);
        end
        "n": begin
          if ($fscanf(fd, "%d", f1) != 1) abortRun("malformed write count record");
          auditTap(f1);
        end
        "r": begin
          if ($fscanf(fd, "%h %d %h", f1, f2, f3) != 3) begin
            abortRun("malformed readback record");
          end
          readRange(f1, f2, f3);
        end
        default: abortRun($sformatf("unknown record type %s in the vector file", tok));
      endcase
    end
    $fclose(fd);
    $display("Verification passed");
    $finish;
  end

endmodule

//--- tests/pixelSystem_vectors.txt
# c eng base count color | s strobe | i wait idle | q cycles quiet | e addr color | n writes left
# r addr count color ; eng, count, cycles, writes decimal ; addr, color hex
# reset state
q 10
# single fill on engine 6
c 6 100 5 a7
s
i
e 100 a7
e 101 a7
e 102 a7
e 103 a7
e 104 a7
n 0
r 100 5 a7
# engines 3 and 9 together, higher index first
c 3 200 1 33
c 9 210 1 99
s
i
e 210 99
e 200 33
n 0
r 200 1 33
r 210 1 99
# all engines contend on disjoint runs
c 0 400 1 c0
c 1 410 2 c1
c 2 420 3 c2
c 3 430 4 c3
c 4 440 1 c4
c 5 450 2 c5
c 6 460 3 c6
c 7 470 4 c7
c 8 480 1 c8
c 9 490 2 c9
c 10 4a0 3 ca
c 11 4b0 4 cb
c 12 4c0 1 cc
c 13 4d0 2 cd
c 14 4e0 3 ce
c 15 4f0 4 cf
s
i
n 40
r 400 1 c0
r 410 2 c1
r 420 3 c2
r 430 4 c3
r 440 1 c4
r 450 2 c5
r 460 3 c6
r 470 4 c7
r 480 1 c8
r 490 2 c9
r 4a0 3 ca
r 4b0 4 cb
r 4c0 1 cc
r 4d0 2 cd
r 4e0 3 ce
r 4f0 4 cf
# overwrite the middle of the first run
c 2 102 2 5e
s
i
e 102 5e
e 103 5e
n 0
r 100 2 a7
r 102 2 5e
r 104 1 a7
# zero count never raises busy
c 5 300 0 ee
s
q 8
n 0
